/* l2_pkg.sv */
`default_nettype none

package l2_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;

    // One L1 request as held in the request buffer
    typedef struct packed {
        addr_t addr;
        word_t wdata;
        strb_t wstrb;
        logic  wr;
    } l1_req_t;

    // Owner of the buffered request, also picks the allocation group
    typedef enum logic {
        SRC_I,
        SRC_D
    } req_src_t;

    typedef struct packed {
        logic  hit;
        logic  hit_way;
        logic  victim_way;
        logic  victim_dirty;
        addr_t victim_addr;
    } lookup_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WB_REQ,
        ST_WB_REL,
        ST_FILL_REQ,
        ST_FILL_REL,
        ST_RESP
    } ctrl_state_t;

    // Byte-strobed merge of one word
    function automatic word_t merge_word(input word_t old_word, input word_t new_word,
                                         input strb_t strb);
        word_t result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

endpackage

`default_nettype wire

/* l2_way_group.sv */
`timescale 1ns/1ps
`default_nettype none

module l2_way_group
    import l2_pkg::*;
#(
    parameter int index_width  = 2,
    parameter int offset_width = 3
) (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire addr_t                         addr,
    input  wire logic                          rd_way,
    input  wire logic                          fill_en,
    input  wire logic [(32<<offset_width)-1:0] fill_line,
    input  wire logic                          word_we,
    input  wire logic                          word_way,
    input  wire strb_t                         wstrb,
    input  wire word_t                         wdata,
    input  wire logic                          touch,
    input  wire logic                          touch_way,
    output lookup_t                            lookup,
    output logic [(32<<offset_width)-1:0]      rd_line
);

    localparam int tag_width  = 30 - index_width - offset_width;
    localparam int line_width = 32 << offset_width;
    localparam int sets       = 1 << index_width;

    typedef logic [tag_width-1:0]    tag_t;
    typedef logic [index_width-1:0]  index_t;
    typedef logic [offset_width-1:0] offset_t;
    typedef logic [line_width-1:0]   line_t;

    tag_t    tag_q   [2][sets];
    line_t   line_q  [2][sets];
    logic    valid_q [2][sets];
    logic    dirty_q [2][sets];
    // Points at the least recently used way of the set
    logic    lru_q   [sets];

    tag_t    tag;
    index_t  index;
    offset_t offset;
    logic    [1:0] way_hit;
    logic    victim;

    assign tag    = addr[31 -: tag_width];
    assign index  = addr[offset_width+2 +: index_width];
    assign offset = addr[2 +: offset_width];

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid_q[w][index] && (tag_q[w][index] == tag);
        end
        // Empty way first, else the LRU way
        if (!valid_q[0][index]) begin
            victim = 1'b0;
        end else if (!valid_q[1][index]) begin
            victim = 1'b1;
        end else begin
            victim = lru_q[index];
        end
        lookup.hit          = |way_hit;
        lookup.hit_way      = way_hit[1];
        lookup.victim_way   = victim;
        lookup.victim_dirty = valid_q[victim][index] && dirty_q[victim][index];
        lookup.victim_addr  = {tag_q[victim][index], index, {(offset_width+2){1'b0}}};
    end

    assign rd_line = line_q[rd_way][index];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < sets; s++) begin
                for (int w = 0; w < 2; w++) begin
                    valid_q[w][s] <= 1'b0;
                    dirty_q[w][s] <= 1'b0;
                end
                lru_q[s] <= 1'b0;
            end
        end else begin
            if (fill_en) begin
                valid_q[victim][index] <= 1'b1;
                dirty_q[victim][index] <= 1'b0;
            end else if (word_we) begin
                dirty_q[word_way][index] <= 1'b1;
            end
            if (touch) begin
                lru_q[index] <= ~touch_way;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_q[victim][index]  <= tag;
            line_q[victim][index] <= fill_line;
        end else if (word_we) begin
            line_q[word_way][index][offset*32 +: 32] <=
                merge_word(line_q[word_way][index][offset*32 +: 32], wdata, wstrb);
        end
    end

endmodule

`default_nettype wire

/* l2_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module l2_arbiter
    import l2_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire logic    i_req,
    input  wire l1_req_t i_cmd,
    input  wire logic    d_req,
    input  wire l1_req_t d_cmd,
    input  wire logic    done,
    input  wire word_t   done_rdata,
    output logic         i_ack,
    output logic         d_ack,
    output word_t        i_rdata,
    output word_t        d_rdata,
    output logic         cur_valid,
    output l1_req_t      cur_req,
    output req_src_t     cur_src
);

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_BUSY,
        ARB_REL
    } arb_state_t;

    arb_state_t state;
    logic       winner_req;

    assign winner_req = (cur_src == SRC_D) ? d_req : i_req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ARB_IDLE;
            cur_valid <= 1'b0;
            cur_src   <= SRC_I;
            i_ack     <= 1'b0;
            d_ack     <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    // Data cache first
                    if (d_req) begin
                        cur_src   <= SRC_D;
                        cur_valid <= 1'b1;
                        state     <= ARB_BUSY;
                    end else if (i_req) begin
                        cur_src   <= SRC_I;
                        cur_valid <= 1'b1;
                        state     <= ARB_BUSY;
                    end
                end
                ARB_BUSY: begin
                    if (done) begin
                        if (cur_src == SRC_D) begin
                            d_ack <= 1'b1;
                        end else begin
                            i_ack <= 1'b1;
                        end
                        state <= ARB_REL;
                    end
                end
                ARB_REL: begin
                    // Hold ack until the winner lets go
                    if (!winner_req) begin
                        i_ack     <= 1'b0;
                        d_ack     <= 1'b0;
                        cur_valid <= 1'b0;
                        state     <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // Request buffer and returned words
    always_ff @(posedge clk) begin
        if (state == ARB_IDLE) begin
            if (d_req) begin
                cur_req <= d_cmd;
            end else if (i_req) begin
                cur_req    <= i_cmd;
                cur_req.wr <= 1'b0;
            end
        end
        if (done) begin
            if (cur_src == SRC_D) begin
                d_rdata <= done_rdata;
            end else begin
                i_rdata <= done_rdata;
            end
        end
    end

endmodule

`default_nettype wire

/* l2_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module l2_ctrl
    import l2_pkg::*;
#(
    parameter int index_width  = 2,
    parameter int offset_width = 3
) (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          cur_valid,
    input  wire l1_req_t                       cur_req,
    input  wire req_src_t                      cur_src,
    input  wire lookup_t                       look_i,
    input  wire lookup_t                       look_d,
    input  wire logic [(32<<offset_width)-1:0] line_i,
    input  wire logic [(32<<offset_width)-1:0] line_d,
    input  wire logic                          mem_ack,
    input  wire logic [(32<<offset_width)-1:0] mem_rline,
    output logic                               done,
    output word_t                              done_rdata,
    output logic                               fill_en_i,
    output logic                               fill_en_d,
    output logic                               word_we_i,
    output logic                               word_we_d,
    output logic                               rd_way_i,
    output logic                               rd_way_d,
    output logic                               touch_i,
    output logic                               touch_d,
    output logic [(32<<offset_width)-1:0]      fill_line,
    output logic                               word_way,
    output strb_t                              wstrb,
    output word_t                              wdata,
    output logic                               mem_req,
    output logic                               mem_we,
    output addr_t                              mem_addr,
    output logic [(32<<offset_width)-1:0]      mem_wline
);

    localparam int tag_width  = 30 - index_width - offset_width;
    localparam int line_width = 32 << offset_width;

    typedef logic [offset_width-1:0] offset_t;

    ctrl_state_t           state;
    logic                  served;
    // Group and way that the request works on
    logic                  grp_d;
    logic                  way_q;
    logic                  hit_any;
    logic                  miss_grp_d;
    lookup_t               miss_look;
    addr_t                 fill_addr;
    offset_t               offset;
    logic [line_width-1:0] sel_line;
    word_t                 old_word;

    assign hit_any    = look_i.hit | look_d.hit;
    assign miss_grp_d = (cur_src == SRC_D);
    assign miss_look  = miss_grp_d ? look_d : look_i;
    assign fill_addr  = {cur_req.addr[31 -: tag_width],
                         cur_req.addr[offset_width+2 +: index_width],
                         {(offset_width+2){1'b0}}};
    assign offset     = cur_req.addr[2 +: offset_width];
    assign sel_line   = grp_d ? line_d : line_i;
    assign old_word   = sel_line[offset*32 +: 32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            served  <= 1'b0;
            mem_req <= 1'b0;
        end else begin
            // Ignore cur_valid until the arbiter has released the request
            if (state == ST_RESP) begin
                served <= 1'b1;
            end else if (!cur_valid) begin
                served <= 1'b0;
            end
            case (state)
                ST_IDLE: begin
                    if (cur_valid && !served) begin
                        state <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    if (hit_any) begin
                        state <= ST_RESP;
                    end else if (miss_look.victim_dirty) begin
                        mem_req <= 1'b1;
                        state   <= ST_WB_REQ;
                    end else begin
                        mem_req <= 1'b1;
                        state   <= ST_FILL_REQ;
                    end
                end
                ST_WB_REQ: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        state   <= ST_WB_REL;
                    end
                end
                ST_WB_REL: begin
                    if (!mem_ack) begin
                        mem_req <= 1'b1;
                        state   <= ST_FILL_REQ;
                    end
                end
                ST_FILL_REQ: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        state   <= ST_FILL_REL;
                    end
                end
                ST_FILL_REL: begin
                    if (!mem_ack) begin
                        state <= ST_RESP;
                    end
                end
                ST_RESP: state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Target way and memory command, stable through each handshake
    always_ff @(posedge clk) begin
        if (state == ST_LOOKUP) begin
            if (hit_any) begin
                grp_d <= look_d.hit;
                way_q <= look_d.hit ? look_d.hit_way : look_i.hit_way;
            end else begin
                grp_d <= miss_grp_d;
                way_q <= miss_look.victim_way;
            end
            mem_we   <= !hit_any && miss_look.victim_dirty;
            mem_addr <= miss_look.victim_dirty ? miss_look.victim_addr : fill_addr;
        end else if (state == ST_WB_REL && !mem_ack) begin
            mem_we   <= 1'b0;
            mem_addr <= fill_addr;
        end
    end

    always_comb begin
        fill_en_i  = (state == ST_FILL_REQ) && mem_ack && !grp_d;
        fill_en_d  = (state == ST_FILL_REQ) && mem_ack && grp_d;
        word_we_i  = (state == ST_RESP) && cur_req.wr && !grp_d;
        word_we_d  = (state == ST_RESP) && cur_req.wr && grp_d;
        touch_i    = (state == ST_RESP) && !grp_d;
        touch_d    = (state == ST_RESP) && grp_d;
        rd_way_i   = way_q;
        rd_way_d   = way_q;
        word_way   = way_q;
        wstrb      = cur_req.wstrb;
        wdata      = cur_req.wdata;
        fill_line  = mem_rline;
        // Victim line while writing back
        mem_wline  = sel_line;
        done       = (state == ST_RESP);
        // A write returns the word as merged
        done_rdata = cur_req.wr ? merge_word(old_word, cur_req.wdata, cur_req.wstrb)
                                : old_word;
    end

endmodule

`default_nettype wire

/* l2_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module l2_cache
    import l2_pkg::*;
#(
    parameter int index_width  = 2,
    parameter int offset_width = 3
) (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          i_req,
    input  wire l1_req_t                       i_cmd,
    output logic                               i_ack,
    output word_t                              i_rdata,
    input  wire logic                          d_req,
    input  wire l1_req_t                       d_cmd,
    output logic                               d_ack,
    output word_t                              d_rdata,
    output logic                               mem_req,
    output logic                               mem_we,
    output addr_t                              mem_addr,
    output logic [(32<<offset_width)-1:0]      mem_wline,
    input  wire logic [(32<<offset_width)-1:0] mem_rline,
    input  wire logic                          mem_ack
);

    localparam int line_width = 32 << offset_width;

    logic                  cur_valid;
    l1_req_t               cur_req;
    req_src_t              cur_src;
    logic                  done;
    word_t                 done_rdata;
    lookup_t               look_i;
    lookup_t               look_d;
    logic [line_width-1:0] line_i;
    logic [line_width-1:0] line_d;
    logic [line_width-1:0] fill_line;
    logic                  fill_en_i;
    logic                  fill_en_d;
    logic                  word_we_i;
    logic                  word_we_d;
    logic                  rd_way_i;
    logic                  rd_way_d;
    logic                  touch_i;
    logic                  touch_d;
    logic                  word_way;
    strb_t                 wstrb;
    word_t                 wdata;

    l2_arbiter u_arb (
        .clk(clk), .rst_n(rst_n),
        .i_req(i_req), .i_cmd(i_cmd), .d_req(d_req), .d_cmd(d_cmd),
        .done(done), .done_rdata(done_rdata),
        .i_ack(i_ack), .d_ack(d_ack), .i_rdata(i_rdata), .d_rdata(d_rdata),
        .cur_valid(cur_valid), .cur_req(cur_req), .cur_src(cur_src)
    );

    // Ways 0 and 1
    l2_way_group #(.index_width(index_width), .offset_width(offset_width)) u_grp_i (
        .clk(clk), .rst_n(rst_n), .addr(cur_req.addr), .rd_way(rd_way_i),
        .fill_en(fill_en_i), .fill_line(fill_line),
        .word_we(word_we_i), .word_way(word_way), .wstrb(wstrb), .wdata(wdata),
        .touch(touch_i), .touch_way(word_way),
        .lookup(look_i), .rd_line(line_i)
    );

    // Ways 2 and 3
    l2_way_group #(.index_width(index_width), .offset_width(offset_width)) u_grp_d (
        .clk(clk), .rst_n(rst_n), .addr(cur_req.addr), .rd_way(rd_way_d),
        .fill_en(fill_en_d), .fill_line(fill_line),
        .word_we(word_we_d), .word_way(word_way), .wstrb(wstrb), .wdata(wdata),
        .touch(touch_d), .touch_way(word_way),
        .lookup(look_d), .rd_line(line_d)
    );

    l2_ctrl #(.index_width(index_width), .offset_width(offset_width)) u_ctrl (
        .clk(clk), .rst_n(rst_n),
        .cur_valid(cur_valid), .cur_req(cur_req), .cur_src(cur_src),
        .look_i(look_i), .look_d(look_d), .line_i(line_i), .line_d(line_d),
        .mem_ack(mem_ack), .mem_rline(mem_rline),
        .done(done), .done_rdata(done_rdata),
        .fill_en_i(fill_en_i), .fill_en_d(fill_en_d),
        .word_we_i(word_we_i), .word_we_d(word_we_d),
        .rd_way_i(rd_way_i), .rd_way_d(rd_way_d),
        .touch_i(touch_i), .touch_d(touch_d),
        .fill_line(fill_line), .word_way(word_way), .wstrb(wstrb), .wdata(wdata),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wline(mem_wline)
    );

endmodule

`default_nettype wire

/* tb_l2_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_l2_cache
    import l2_pkg::*;
();

    localparam int offset_width = 3;
    localparam int line_words   = 1 << offset_width;
    localparam int line_width   = 32 * line_words;
    localparam int mem_words    = 1024;
    localparam int ack_timeout  = 300;
    localparam int mem_timeout  = 300;
    // Negedges from raising req until ack is seen on a hit
    localparam int hit_cycles   = 4;

    logic                  clk;
    logic                  rst_n;
    logic                  i_req;
    l1_req_t               i_cmd;
    logic                  i_ack;
    word_t                 i_rdata;
    logic                  d_req;
    l1_req_t               d_cmd;
    logic                  d_ack;
    word_t                 d_rdata;
    logic                  mem_req;
    logic                  mem_we;
    addr_t                 mem_addr;
    logic [line_width-1:0] mem_wline;
    logic [line_width-1:0] mem_rline;
    logic                  mem_ack;

    word_t       mem_array [mem_words];
    word_t       mirror    [mem_words];
    int          errors;
    int          timeouts;
    int          line_reads;
    int          line_writes;
    logic [31:0] seq_rng;

    l2_cache dut (
        .clk(clk), .rst_n(rst_n),
        .i_req(i_req), .i_cmd(i_cmd), .i_ack(i_ack), .i_rdata(i_rdata),
        .d_req(d_req), .d_cmd(d_cmd), .d_ack(d_ack), .d_rdata(d_rdata),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wline(mem_wline), .mem_rline(mem_rline), .mem_ack(mem_ack)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Power-up memory content
    function automatic word_t init_word(input addr_t a);
        return (a * 32'h9e37_79b1) ^ 32'h0f0f_5a5a ^ {a[15:0], a[31:16]};
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        if (got !== expected) begin
            $display("error at time %0t: %s is %h, expected %h", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic mirror_write(input addr_t addr, input word_t wdata, input strb_t strb);
        logic [9:0] widx;
        widx = addr[11:2];
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                mirror[widx][b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
    endtask

    task automatic d_access(input addr_t addr, input logic wr, input word_t wdata,
                            input strb_t strb, output int cycles);
        int wait_cnt;
        @(negedge clk);
        d_cmd.addr  = addr;
        d_cmd.wdata = wdata;
        d_cmd.wstrb = strb;
        d_cmd.wr    = wr;
        d_req       = 1'b1;
        if (wr) begin
            mirror_write(addr, wdata, strb);
        end
        cycles = 0;
        while (!d_ack && cycles < ack_timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (!d_ack) begin
            $display("timeout: no d_ack for the data access to %h", addr);
            timeouts++;
        end else begin
            compare_value("d_rdata", d_rdata, mirror[addr[11:2]]);
        end
        d_req    = 1'b0;
        wait_cnt = 0;
        while (d_ack && wait_cnt < ack_timeout) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (d_ack) begin
            $display("timeout: d_ack stayed high after d_req dropped");
            timeouts++;
        end
    endtask

    task automatic i_access(input addr_t addr, output int cycles);
        int wait_cnt;
        @(negedge clk);
        i_cmd.addr  = addr;
        i_cmd.wdata = '0;
        i_cmd.wstrb = '0;
        i_cmd.wr    = 1'b0;
        i_req       = 1'b1;
        cycles = 0;
        while (!i_ack && cycles < ack_timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (!i_ack) begin
            $display("timeout: no i_ack for the instruction read of %h", addr);
            timeouts++;
        end else begin
            compare_value("i_rdata", i_rdata, mirror[addr[11:2]]);
        end
        i_req    = 1'b0;
        wait_cnt = 0;
        while (i_ack && wait_cnt < ack_timeout) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (i_ack) begin
            $display("timeout: i_ack stayed high after i_req dropped");
            timeouts++;
        end
    endtask

    // Line memory with a random response delay of 0 to 3 cycles
    initial begin : memory_model
        logic [31:0] mem_rng;
        logic [9:0]  widx;
        int          delay;
        int          wait_cnt;
        mem_rng   = 32'd59142;
        mem_ack   = 1'b0;
        mem_rline = '0;
        forever begin
            @(negedge clk);
            if (rst_n && mem_req && !mem_ack) begin
                mem_rng = xorshift(mem_rng);
                delay   = int'(mem_rng[1:0]);
                repeat (delay) @(negedge clk);
                for (int w = 0; w < line_words; w++) begin
                    widx = mem_addr[11:2] + 10'(w);
                    if (mem_we) begin
                        mem_array[widx] = mem_wline[w*32 +: 32];
                    end else begin
                        mem_rline[w*32 +: 32] = mem_array[widx];
                    end
                end
                if (mem_we) begin
                    line_writes++;
                end else begin
                    line_reads++;
                end
                mem_ack  = 1'b1;
                wait_cnt = 0;
                while (mem_req && wait_cnt < mem_timeout) begin
                    @(negedge clk);
                    wait_cnt++;
                end
                if (mem_req) begin
                    $display("timeout: mem_req stayed high after mem_ack rose");
                    timeouts++;
                end
                mem_ack = 1'b0;
            end
        end
    end

    task automatic reset_state();
        compare_value("i_ack", {31'b0, i_ack}, 32'h0);
        compare_value("d_ack", {31'b0, d_ack}, 32'h0);
        compare_value("mem_req", {31'b0, mem_req}, 32'h0);
    endtask

    task automatic read_miss_then_hit();
        int cycles;
        int reads_before;
        reads_before = line_reads;
        d_access(32'h0000_0040, 1'b0, '0, '0, cycles);
        compare_value("line reads", line_reads, reads_before + 1);
        d_access(32'h0000_0044, 1'b0, '0, '0, cycles);
        compare_value("line reads", line_reads, reads_before + 1);
        compare_value("hit ack latency", cycles, hit_cycles);
    endtask

    task automatic partial_write_merge();
        int cycles;
        int writes_before;
        writes_before = line_writes;
        d_access(32'h0000_0048, 1'b1, 32'h1122_3344, 4'b0011, cycles);
        d_access(32'h0000_0048, 1'b1, 32'haabb_ccdd, 4'b1100, cycles);
        d_access(32'h0000_004c, 1'b1, 32'h5566_7788, 4'b0100, cycles);
        d_access(32'h0000_0048, 1'b0, '0, '0, cycles);
        d_access(32'h0000_004c, 1'b0, '0, '0, cycles);
        compare_value("line writes", line_writes, writes_before);
    endtask

    // 0x100, 0x180 and 0x200 share set 0
    task automatic dirty_eviction();
        int cycles;
        int reads_before;
        int writes_before;
        d_access(32'h0000_0104, 1'b1, 32'hdead_beef, 4'b1111, cycles);
        d_access(32'h0000_0188, 1'b1, 32'hcafe_f00d, 4'b0110, cycles);
        writes_before = line_writes;
        d_access(32'h0000_0200, 1'b0, '0, '0, cycles);
        compare_value("line writes", line_writes, writes_before + 1);
        reads_before = line_reads;
        d_access(32'h0000_0104, 1'b0, '0, '0, cycles);
        compare_value("line reads", line_reads, reads_before + 1);
    endtask

    task automatic instr_read_of_data_line();
        int cycles;
        int reads_before;
        reads_before = line_reads;
        i_access(32'h0000_0048, cycles);
        compare_value("line reads", line_reads, reads_before);
    endtask

    task automatic simultaneous_requests();
        int cycles_d;
        int cycles_i;
        fork
            d_access(32'h0000_004c, 1'b0, '0, '0, cycles_d);
            i_access(32'h0000_0300, cycles_i);
        join
        if (!(cycles_d < cycles_i)) begin
            $display("d_ack did not rise before i_ack (%0d and %0d cycles)",
                     cycles_d, cycles_i);
            errors++;
        end
    endtask

    // Window of 32 lines, twice the cache size
    task automatic random_mix();
        int          cycles;
        logic [31:0] r;
        addr_t       addr;
        for (int n = 0; n < 200; n++) begin
            seq_rng = xorshift(seq_rng);
            r       = seq_rng;
            addr    = {22'b0, r[9:2], 2'b00};
            if (r[10]) begin
                i_access(addr, cycles);
            end else begin
                seq_rng = xorshift(seq_rng);
                d_access(addr, r[11], seq_rng, r[15:12], cycles);
            end
        end
    endtask

    initial begin : stimulus
        rst_n       = 1'b0;
        i_req       = 1'b0;
        d_req       = 1'b0;
        i_cmd       = '0;
        d_cmd       = '0;
        errors      = 0;
        timeouts    = 0;
        line_reads  = 0;
        line_writes = 0;
        seq_rng     = 32'd59142;
        for (int k = 0; k < mem_words; k++) begin
            mem_array[k] = init_word(addr_t'(k << 2));
            mirror[k]    = init_word(addr_t'(k << 2));
        end
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        reset_state();
        read_miss_then_hit();
        partial_write_merge();
        dirty_eviction();
        instr_read_of_data_line();
        simultaneous_requests();
        random_mix();

        $display("errors %0d, timeouts %0d, line reads %0d, line writes %0d",
                 errors, timeouts, line_reads, line_writes);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
l2_pkg.sv
l2_way_group.sv
l2_arbiter.sv
l2_ctrl.sv
l2_cache.sv
tb_l2_cache.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= list.f
TB_TOP    ?= tb_l2_cache
RTL_TOP   ?= l2_cache
RTL_SRCS  ?= l2_pkg.sv l2_way_group.sv l2_arbiter.sv l2_ctrl.sv l2_cache.sv
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "FAIL: see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "Simulation completed successfully" $(LOG) || \
		(echo "FAIL: no result in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
